/* Makefile */
.PHONY: all lint clean

all: obj_dir/VneoC1Tb
	@out="$$(./obj_dir/VneoC1Tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Regression passed"

obj_dir/VneoC1Tb: filelist.f $(wildcard hdl/*.sv tb/*.sv tb/*.svh)
	verilator --binary --timing -j 0 --top-module neoC1Tb -f filelist.f

lint:
	verilator --lint-only --timing --top-module neoC1Tb -f filelist.f

clean:
	rm -rf obj_dir

/* filelist.f */
+incdir+tb
hdl/c1Pkg.sv
hdl/c1AddrDecode.sv
hdl/c1WaitGen.sv
hdl/c1SoundLatch.sv
hdl/c1IoRead.sv
hdl/neoC1.sv
tb/neoC1Tb.sv

/* hdl/c1AddrDecode.sv */
`timescale 1ns/10ps
`default_nettype none

module c1AddrDecode (
	input wire c1Pkg::c1Bus bus,
	output c1Pkg::c1Zones zones,
	output c1Pkg::c1Selects sel
);
	import c1Pkg::*;

	logic [3:0] majorAddr;	// A23..A20
	logic [2:0] ioSub;	// A19..A17
	logic ioHit;
	logic c1Regs;
	logic rdL;
	logic rdU;
	logic wrL;
	logic wrU;
	logic wordRd;
	logic wordWr;
	logic anyByte;

	assign majorAddr = bus.addr[6:3];
	assign ioSub = bus.addr[2:0];

	assign ioHit = (majorAddr == 4'h3);
	// Even bytes of the I/O area hold the C1 registers
	assign c1Regs = ioHit & ~bus.nUds;

	always_comb begin
		zones = '0;
		case (majorAddr)
			4'h0: zones.rom = 1'b1;
			4'h1: zones.wram = 1'b1;
			4'h2: zones.port = 1'b1;
			4'h3: zones.io = 1'b1;
			4'h4, 4'h5, 4'h6, 4'h7: zones.pal = 1'b1;
			4'h8, 4'h9, 4'hA, 4'hB: zones.card = 1'b1;
			4'hC: zones.srom = 1'b1;
			4'hD: zones.sram = 1'b1;
			default: ;	// E and F unmapped
		endcase

		zones.ctrl1 = c1Regs & bus.rw & (ioSub == 3'b000);
		zones.icom = c1Regs & (ioSub == 3'b001);	// Both directions
		zones.ctrl2 = c1Regs & bus.rw & ~ioSub[2] & ioSub[1];
		zones.statusB = c1Regs & bus.rw & (ioSub == 3'b100);
		zones.lspc = ioHit & (ioSub == 3'b110);
	end

	// Qualified strobes, nAs and direction folded in
	assign rdL = ~bus.nAs & bus.rw & ~bus.nLds;
	assign rdU = ~bus.nAs & bus.rw & ~bus.nUds;
	assign wrL = ~bus.nAs & ~bus.rw & ~bus.nLds;
	assign wrU = ~bus.nAs & ~bus.rw & ~bus.nUds;
	assign wordRd = rdL & rdU;
	assign wordWr = wrL & wrU;
	assign anyByte = ~bus.nAs & ~(bus.nLds & bus.nUds);

	// Program ROM, read only
	assign sel.nRomOeL = ~(zones.rom & rdL);
	assign sel.nRomOeU = ~(zones.rom & rdU);

	assign sel.nPortOeL = ~(zones.port & rdL);
	assign sel.nPortOeU = ~(zones.port & rdU);
	assign sel.nPortWeL = ~(zones.port & wrL);
	assign sel.nPortWeU = ~(zones.port & wrU);
	assign sel.nPortAdrs = ~(zones.port & anyByte);	// Address latch for the cartridge

	assign sel.nWrL = ~(zones.wram & rdL);
	assign sel.nWrU = ~(zones.wram & rdU);
	assign sel.nWwL = ~(zones.wram & wrL);
	assign sel.nWwU = ~(zones.wram & wrU);

	assign sel.nSromOeL = ~(zones.srom & rdL);
	assign sel.nSromOeU = ~(zones.srom & rdU);

	// Backup RAM
	assign sel.nSramOeL = ~(zones.sram & rdL);
	assign sel.nSramOeU = ~(zones.sram & rdU);
	assign sel.nSramWeL = ~(zones.sram & wrL);
	assign sel.nSramWeU = ~(zones.sram & wrU);

	// Video controller and card only take word accesses
	assign sel.nLspOe = ~(zones.lspc & wordRd);
	assign sel.nLspWe = ~(zones.lspc & wordWr);
	assign sel.nCrdO = ~(zones.card & wordRd);
	assign sel.nCrdW = ~(zones.card & wordWr);
	assign sel.nCrdC = sel.nCrdO & sel.nCrdW;	// Any card access

	// Odd-byte DIP reads and bit writes
	assign sel.nDipRd0 = ~(ioHit & rdL & (ioSub == 3'b000));
	assign sel.nDipRd1 = ~(ioHit & rdL & (ioSub == 3'b001));
	assign sel.nBitW0 = ~(ioHit & wrL & (ioSub == 3'b100));
	assign sel.nBitW1 = ~(ioHit & wrL & (ioSub == 3'b101));

	assign sel.nPal = ~(zones.pal & anyByte);
	assign sel.nCtrl1Zone = ~(zones.ctrl1 & ~bus.nAs);
	assign sel.nCtrl2Zone = ~(zones.ctrl2 & ~bus.nAs);

endmodule

`default_nettype wire

/* hdl/c1IoRead.sv */
`timescale 1ns/10ps
`default_nettype none

module c1IoRead (
	input wire c1Pkg::c1Zones zones,
	input wire nAs,
	input wire rw,
	input wire [7:0] p1In,
	input wire [7:0] p2In,
	input wire nCd1,
	input wire nCd2,
	input wire nWp,
	input wire [7:0] sdd,
	output logic [7:0] dataOut,
	output logic dataOe
);
	import c1Pkg::*;

	logic readCycle;
	logic [7:0] statusByte;

	assign readCycle = ~nAs & rw;

	// Card detect and write protect in the low bits, rest floats high
	assign statusByte = {5'b11111, nWp, nCd2, nCd1};

	always_comb begin
		dataOut = 8'h00;
		dataOe = 1'b0;
		if (readCycle) begin
			if (zones.ctrl1) begin
				dataOut = p1In;
				dataOe = 1'b1;
			end else if (zones.ctrl2) begin
				dataOut = p2In;
				dataOe = 1'b1;
			end else if (zones.statusB) begin
				dataOut = statusByte;
				dataOe = 1'b1;
			end else if (zones.icom) begin
				dataOut = sdd;	// Reply from the sound CPU
				dataOe = 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

/* hdl/c1Pkg.sv */
`default_nettype none

package c1Pkg;

	// Longest DTACK delay any zone can ask for
	localparam int unsigned maxWaits = 3;

	typedef logic [$clog2(maxWaits + 1) - 1:0] waitCnt;

	localparam waitCnt romWaits = 2'd1;	// Slow ROM, nRomWait low
	localparam waitCnt noWaits = 2'd0;

	// One CPU bus state, address bits 23 to 17
	typedef struct packed {
		logic [6:0] addr;
		logic rw;
		logic nAs;
		logic nLds;
		logic nUds;
	} c1Bus;

	// Active-high zone hits, address decode only
	typedef struct packed {
		logic rom;
		logic wram;
		logic port;
		logic io;
		logic ctrl1;
		logic icom;
		logic ctrl2;
		logic statusB;
		logic lspc;
		logic pal;
		logic card;
		logic srom;
		logic sram;
	} c1Zones;

	// Active-low select outputs
	typedef struct packed {
		logic nRomOeL;
		logic nRomOeU;
		logic nPortOeL;
		logic nPortOeU;
		logic nPortWeL;
		logic nPortWeU;
		logic nPortAdrs;
		logic nWrL;	// Work RAM read
		logic nWrU;
		logic nWwL;	// Work RAM write
		logic nWwU;
		logic nSromOeL;
		logic nSromOeU;
		logic nSramOeL;
		logic nSramOeU;
		logic nSramWeL;
		logic nSramWeU;
		logic nLspOe;
		logic nLspWe;
		logic nCrdO;
		logic nCrdW;
		logic nCrdC;
		logic nDipRd0;
		logic nDipRd1;
		logic nBitW0;
		logic nBitW1;
		logic nPal;
		logic nCtrl1Zone;
		logic nCtrl2Zone;
	} c1Selects;

endpackage

`default_nettype wire

/* hdl/c1SoundLatch.sv */
`timescale 1ns/10ps
`default_nettype none

module c1SoundLatch (
	input wire clk68k,
	input wire arstN,
	input wire c1Pkg::c1Bus bus,
	input wire icomHit,
	input wire [7:0] dataIn,
	output logic [7:0] soundCmd,
	output logic soundCmdStb
);
	import c1Pkg::*;

	logic served;	// Command already taken in this bus cycle
	logic capture;

	// Write to the communication zone not yet latched
	assign capture = ~bus.nAs & ~bus.rw & icomHit & ~served;

	always_ff @(posedge clk68k or negedge arstN) begin
		if (!arstN) begin
			served <= 1'b0;
			soundCmdStb <= 1'b0;
			soundCmd <= '0;
		end else begin
			soundCmdStb <= capture;	// One clock wide
			if (bus.nAs) begin
				served <= 1'b0;
			end else if (capture) begin
				served <= 1'b1;
			end
			if (capture) begin
				soundCmd <= dataIn;
			end
		end
	end

endmodule

`default_nettype wire

/* hdl/c1WaitGen.sv */
`timescale 1ns/10ps
`default_nettype none

module c1WaitGen #(
	parameter int unsigned cardWaits = 2
) (
	input wire clk68k,
	input wire arstN,
	input wire nAs,
	input wire c1Pkg::c1Zones zones,
	input wire nRomWait,
	input wire nPWait0,
	input wire nPWait1,
	output logic nDtack
);
	import c1Pkg::*;

	localparam waitCnt cardCnt = waitCnt'(cardWaits);

	waitCnt target;	// Waits for the zone being accessed
	waitCnt count;	// Edges already spent waiting

	always_comb begin
		if (zones.rom) begin
			target = nRomWait ? noWaits : romWaits;
		end else if (zones.port) begin
			// Cartridge asks for 0 to 3 waits, pins are active low
			target = {~nPWait1, ~nPWait0};
		end else if (zones.card) begin
			target = cardCnt;
		end else begin
			target = noWaits;
		end
	end

	always_ff @(posedge clk68k or negedge arstN) begin
		if (!arstN) begin
			count <= '0;
			nDtack <= 1'b1;
		end else if (nAs) begin
			// Bus idle, ready for the next cycle
			count <= '0;
			nDtack <= 1'b1;
		end else if (nDtack) begin
			if (count == target) begin
				nDtack <= 1'b0;
			end else begin
				count <= count + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

/* hdl/neoC1.sv */
`timescale 1ns/10ps
`default_nettype none

module neoC1 #(
	parameter int unsigned cardWaits = 2
) (
	input wire clk68k,
	input wire arstN,
	input wire c1Pkg::c1Bus bus,
	input wire [7:0] dataIn,	// Upper data byte from the CPU
	input wire [7:0] p1In,
	input wire [7:0] p2In,
	input wire nCd1,
	input wire nCd2,
	input wire nWp,
	input wire nRomWait,
	input wire nPWait0,
	input wire nPWait1,
	input wire [7:0] sdd,
	output c1Pkg::c1Selects sel,
	output logic [7:0] dataOut,
	output logic dataOe,
	output logic nDtack,
	output logic [7:0] soundCmd,
	output logic soundCmdStb
);
	import c1Pkg::*;

	c1Zones zones;

	c1AddrDecode uDecode (
		.bus(bus),
		.zones(zones),
		.sel(sel)
	);

	// DTACK with per-zone wait states
	c1WaitGen #(
		.cardWaits(cardWaits)
	) uWaitGen (
		.clk68k(clk68k),
		.arstN(arstN),
		.nAs(bus.nAs),
		.zones(zones),
		.nRomWait(nRomWait),
		.nPWait0(nPWait0),
		.nPWait1(nPWait1),
		.nDtack(nDtack)
	);

	c1SoundLatch uSoundLatch (
		.clk68k(clk68k),
		.arstN(arstN),
		.bus(bus),
		.icomHit(zones.icom),
		.dataIn(dataIn),
		.soundCmd(soundCmd),
		.soundCmdStb(soundCmdStb)
	);

	// Controller, status and sound reply reads
	c1IoRead uIoRead (
		.zones(zones),
		.nAs(bus.nAs),
		.rw(bus.rw),
		.p1In(p1In),
		.p2In(p2In),
		.nCd1(nCd1),
		.nCd2(nCd2),
		.nWp(nWp),
		.sdd(sdd),
		.dataOut(dataOut),
		.dataOe(dataOe)
	);

endmodule

`default_nettype wire

/* tb/neoC1TbVectors.svh */
// Row: addr A23..A17, strobes, dataIn, p1In, p2In, sdd, pins, then expected
// sel, dataOut, dataOe, wait count, strobe, byte source (random when not table)
// Select groups: Rom 2 Port 5 Wram 4 Srom 2 Sram 4 Lsp 2 Card 3 DipBit 4 Pal+Ctrl 3

localparam int numVecs = 28;

localparam vecEntry vectors [numVecs] = '{
	{7'h00, rdWord, 8'h00, 8'h00, 8'h00, 8'h00, 6'b111011,	// ROM word, slow
		29'b00_11111_1111_11_1111_11_111_1111_111, 8'h00, 1'b0, 2'd1, 1'b0, fromTable},
	{7'h00, rdUpper, 8'h00, 8'h00, 8'h00, 8'h00, 6'b111111,
		29'b10_11111_1111_11_1111_11_111_1111_111, 8'h00, 1'b0, 2'd0, 1'b0, fromTable},
	{7'h00, wrWord, 8'h11, 8'h00, 8'h00, 8'h00, 6'b111111,	// ROM has no write
		29'b11_11111_1111_11_1111_11_111_1111_111, 8'h00, 1'b0, 2'd0, 1'b0, fromTable},
	{7'h08, rdLower, 8'h00, 8'h00, 8'h00, 8'h00, 6'b111111,
		29'b11_11111_0111_11_1111_11_111_1111_111, 8'h00, 1'b0, 2'd0, 1'b0, fromTable},
	{7'h08, wrUpper, 8'h3C, 8'h00, 8'h00, 8'h00, 6'b111111,
		29'b11_11111_1110_11_1111_11_111_1111_111, 8'h00, 1'b0, 2'd0, 1'b0, fromTable},
	{7'h10, rdUpper, 8'h00, 8'h00, 8'h00, 8'h00, 6'b111111,	// Port, no waits
		29'b11_10110_1111_11_1111_11_111_1111_111, 8'h00, 1'b0, 2'd0, 1'b0, fromTable},
	{7'h10, wrLower, 8'h00, 8'h00, 8'h00, 8'h00, 6'b111110,
		29'b11_11010_1111_11_1111_11_111_1111_111, 8'h00, 1'b0, 2'd1, 1'b0, fromTable},
	{7'h10, rdWord, 8'h00, 8'h00, 8'h00, 8'h00, 6'b111101,
		29'b11_00110_1111_11_1111_11_111_1111_111, 8'h00, 1'b0, 2'd2, 1'b0, fromTable},
	{7'h10, wrWord, 8'h00, 8'h00, 8'h00, 8'h00, 6'b111100,	// Port, 3 waits
		29'b11_11000_1111_11_1111_11_111_1111_111, 8'h00, 1'b0, 2'd3, 1'b0, fromTable},
	{7'h60, rdWord, 8'h00, 8'h00, 8'h00, 8'h00, 6'b111111,
		29'b11_11111_1111_00_1111_11_111_1111_111, 8'h00, 1'b0, 2'd0, 1'b0, fromTable},
	{7'h68, rdUpper, 8'h00, 8'h00, 8'h00, 8'h00, 6'b111111,
		29'b11_11111_1111_11_1011_11_111_1111_111, 8'h00, 1'b0, 2'd0, 1'b0, fromTable},
	{7'h68, wrLower, 8'h00, 8'h00, 8'h00, 8'h00, 6'b111111,
		29'b11_11111_1111_11_1101_11_111_1111_111, 8'h00, 1'b0, 2'd0, 1'b0, fromTable},
	{7'h20, wrUpper, 8'h00, 8'h00, 8'h00, 8'h00, 6'b111111,	// Palette
		29'b11_11111_1111_11_1111_11_111_1111_011, 8'h00, 1'b0, 2'd0, 1'b0, fromTable},
	{7'h38, rdWord, 8'h00, 8'h00, 8'h00, 8'h00, 6'b111111,
		29'b11_11111_1111_11_1111_11_111_1111_011, 8'h00, 1'b0, 2'd0, 1'b0, fromTable},
	{7'h40, rdWord, 8'h00, 8'h00, 8'h00, 8'h00, 6'b111111,	// Memory card
		29'b11_11111_1111_11_1111_11_010_1111_111, 8'h00, 1'b0, cardCnt, 1'b0, fromTable},
	{7'h58, wrWord, 8'h00, 8'h00, 8'h00, 8'h00, 6'b111111,
		29'b11_11111_1111_11_1111_11_100_1111_111, 8'h00, 1'b0, cardCnt, 1'b0, fromTable},
	{7'h40, rdUpper, 8'h00, 8'h00, 8'h00, 8'h00, 6'b111111,	// Card needs a word
		29'b11_11111_1111_11_1111_11_111_1111_111, 8'h00, 1'b0, cardCnt, 1'b0, fromTable},
	{7'h18, rdWord, 8'h00, 8'h00, 8'h00, 8'h00, 6'b111111,	// CTRL1 plus DIP
		29'b11_11111_1111_11_1111_11_111_0111_101, 8'h00, 1'b1, 2'd0, 1'b0, fromP1},
	{7'h1A, rdUpper, 8'h00, 8'h00, 8'h00, 8'h00, 6'b111111,	// CTRL2
		29'b11_11111_1111_11_1111_11_111_1111_110, 8'h00, 1'b1, 2'd0, 1'b0, fromP2},
	{7'h1C, rdUpper, 8'h00, 8'h12, 8'h34, 8'h56, 6'b010111,	// STATUSB
		29'b11_11111_1111_11_1111_11_111_1111_111, 8'hFA, 1'b1, 2'd0, 1'b0, fromTable},
	{7'h19, rdLower, 8'h00, 8'h12, 8'h34, 8'h56, 6'b111111,	// DIP 1
		29'b11_11111_1111_11_1111_11_111_1011_111, 8'h00, 1'b0, 2'd0, 1'b0, fromTable},
	{7'h1C, wrLower, 8'h00, 8'h00, 8'h00, 8'h00, 6'b111111,
		29'b11_11111_1111_11_1111_11_111_1101_111, 8'h00, 1'b0, 2'd0, 1'b0, fromTable},
	{7'h1D, wrLower, 8'h00, 8'h00, 8'h00, 8'h00, 6'b111111,
		29'b11_11111_1111_11_1111_11_111_1110_111, 8'h00, 1'b0, 2'd0, 1'b0, fromTable},
	{7'h19, rdUpper, 8'h00, 8'h00, 8'h00, 8'h00, 6'b111111,	// Sound reply
		29'b11_11111_1111_11_1111_11_111_1111_111, 8'h00, 1'b1, 2'd0, 1'b0, fromSdd},
	{7'h19, wrUpper, 8'hA5, 8'h00, 8'h00, 8'h00, 6'b111111,	// Sound command
		29'b11_11111_1111_11_1111_11_111_1111_111, 8'h00, 1'b0, 2'd0, 1'b1, fromTable},
	{7'h1E, rdWord, 8'h00, 8'h00, 8'h00, 8'h00, 6'b111111,	// LSPC
		29'b11_11111_1111_11_1111_01_111_1111_111, 8'h00, 1'b0, 2'd0, 1'b0, fromTable},
	{7'h1E, wrWord, 8'h00, 8'h00, 8'h00, 8'h00, 6'b111111,
		29'b11_11111_1111_11_1111_10_111_1111_111, 8'h00, 1'b0, 2'd0, 1'b0, fromTable},
	{7'h1E, wrUpper, 8'h00, 8'h00, 8'h00, 8'h00, 6'b111111,
		29'b11_11111_1111_11_1111_11_111_1111_111, 8'h00, 1'b0, 2'd0, 1'b0, fromTable}
};

/* tb/neoC1Tb.sv */
`timescale 1ns/10ps
`default_nettype none

module neoC1Tb;
	import c1Pkg::*;

	localparam int periodNs = 40;
	localparam int resetCycles = 5;
	localparam int unsigned cardWaits = 2;
	localparam waitCnt cardCnt = waitCnt'(cardWaits);

	// Bus strobe patterns {rw, nAs, nLds, nUds} with nAs low
	localparam logic [3:0] rdWord = 4'b1000;
	localparam logic [3:0] rdUpper = 4'b1010;
	localparam logic [3:0] rdLower = 4'b1001;
	localparam logic [3:0] wrWord = 4'b0000;
	localparam logic [3:0] wrUpper = 4'b0010;
	localparam logic [3:0] wrLower = 4'b0001;

	// Where the expected read byte comes from
	localparam logic [1:0] fromTable = 2'd0;
	localparam logic [1:0] fromP1 = 2'd1;
	localparam logic [1:0] fromP2 = 2'd2;
	localparam logic [1:0] fromSdd = 2'd3;

	typedef struct packed {
		logic [6:0] addr;	// A23..A17
		logic [3:0] mode;
		logic [7:0] dataIn;
		logic [7:0] p1;
		logic [7:0] p2;
		logic [7:0] sdd;
		logic [5:0] pins;	// nCd1 nCd2 nWp nRomWait nPWait1 nPWait0
		c1Selects expSel;
		logic [7:0] expData;
		logic expOe;
		waitCnt expWaits;
		logic expStb;
		logic [1:0] src;
	} vecEntry;

	`include "neoC1TbVectors.svh"

	logic clk68k;
	logic arstN;
	c1Bus bus;
	logic [7:0] dataIn;
	logic [7:0] p1In;
	logic [7:0] p2In;
	logic nCd1;
	logic nCd2;
	logic nWp;
	logic nRomWait;
	logic nPWait0;
	logic nPWait1;
	logic [7:0] sdd;
	c1Selects sel;
	logic [7:0] dataOut;
	logic dataOe;
	logic nDtack;
	logic [7:0] soundCmd;
	logic soundCmdStb;

	int unsigned seedInit;
	int testErrors = 0;
	int totalErrors = 0;
	int testsRun = 0;
	int testsFailed = 0;
	int stbPulses = 0;	// Sound strobes seen since reset

	neoC1 #(
		.cardWaits(cardWaits)
	) dut0 (
		.clk68k(clk68k),
		.arstN(arstN),
		.bus(bus),
		.dataIn(dataIn),
		.p1In(p1In),
		.p2In(p2In),
		.nCd1(nCd1),
		.nCd2(nCd2),
		.nWp(nWp),
		.nRomWait(nRomWait),
		.nPWait0(nPWait0),
		.nPWait1(nPWait1),
		.sdd(sdd),
		.sel(sel),
		.dataOut(dataOut),
		.dataOe(dataOe),
		.nDtack(nDtack),
		.soundCmd(soundCmd),
		.soundCmdStb(soundCmdStb)
	);

	initial begin
		clk68k = 1'b0;
		forever #(periodNs / 2) clk68k = ~clk68k;
	end

	// Counts every clock the sound strobe is high
	always @(negedge clk68k) begin
		if (soundCmdStb) begin
			stbPulses++;
		end
	end

	task automatic checkSelects(input string name, input c1Selects got, input c1Selects exp);
		if (got !== exp) begin
			$display("CHECK FAILED %s: got %h expected %h", name, got, exp);
			testErrors++;
		end
	endtask

	task automatic checkByte(input string name, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp) begin
			$display("CHECK FAILED %s: got %h expected %h", name, got, exp);
			testErrors++;
		end
	endtask

	task automatic checkWaits(input string name, input waitCnt got, input waitCnt exp);
		if (got !== exp) begin
			$display("CHECK FAILED %s: got %h expected %h", name, got, exp);
			testErrors++;
		end
	endtask

	task automatic reportProblem(input string what);
		$display("ERROR %s", what);
		testErrors++;
	endtask

	task automatic closeTest(input string label);
		if (testErrors == 0) begin
			$display("PASS %s", label);
		end else begin
			$display("FAIL %s (%0d errors)", label, testErrors);
			testsFailed++;
		end
		testsRun++;
		totalErrors += testErrors;
		testErrors = 0;
	endtask

	// One CPU bus cycle entered 2 ns after a rising edge
	task automatic runCycle(input int idx);
		vecEntry v;
		int edges;
		int stbBefore;
		logic [7:0] expData;
		v = vectors[idx];
		bus = {v.addr, v.mode};
		dataIn = v.dataIn;
		{nCd1, nCd2, nWp, nRomWait, nPWait1, nPWait0} = v.pins;
		if (v.src == fromTable) begin
			p1In = v.p1;
			p2In = v.p2;
			sdd = v.sdd;
		end else begin
			p1In = 8'($urandom);
			p2In = 8'($urandom);
			sdd = 8'($urandom);
		end
		case (v.src)
			fromP1: expData = p1In;
			fromP2: expData = p2In;
			fromSdd: expData = sdd;
			default: expData = v.expData;
		endcase
		stbBefore = stbPulses;
		#1;
		checkSelects("sel", sel, v.expSel);
		checkByte("dataOut", dataOut, expData);
		checkByte("dataOe", {7'd0, dataOe}, {7'd0, v.expOe});
		edges = 0;
		while (nDtack && edges <= int'(maxWaits) + 1) begin
			@(posedge clk68k);
			#2;
			edges++;
		end
		if (nDtack) begin
			reportProblem("nDtack never asserted during the bus cycle");
		end else begin
			checkWaits("waitStates", waitCnt'(edges - 1), v.expWaits);
			@(posedge clk68k);	// CPU keeps nAs low one more clock
			#2;
			if (nDtack) begin
				reportProblem("nDtack released while nAs was still low");
			end
		end
		bus.nAs = 1'b1;	// End of cycle
		#1;
		checkSelects("selIdle", sel, '1);
		checkByte("dataOeIdle", {7'd0, dataOe}, 8'd0);
		edges = 0;
		while (!nDtack && edges < 3) begin
			@(posedge clk68k);
			#2;
			edges++;
		end
		if (!nDtack) begin
			reportProblem("nDtack stayed low after nAs was released");
		end
		checkByte("soundCmdStbCount", 8'(stbPulses - stbBefore), {7'd0, v.expStb});
		if (v.expStb) begin
			checkByte("soundCmd", soundCmd, v.dataIn);
		end
		closeTest($sformatf("cycle %0d addr %h mode %b", idx, v.addr, v.mode));
	endtask

	initial begin
		seedInit = $urandom(22338);
		arstN = 1'b0;
		bus = {7'h7F, 4'b1111};	// Idle bus
		dataIn = 8'h00;
		p1In = 8'h00;
		p2In = 8'h00;
		sdd = 8'h00;
		{nCd1, nCd2, nWp, nRomWait, nPWait1, nPWait0} = 6'b111111;
		repeat (resetCycles) @(posedge clk68k);
		#2;
		arstN = 1'b1;
		@(posedge clk68k);
		#2;
		checkByte("nDtack", {7'd0, nDtack}, 8'd1);
		checkByte("soundCmdStb", {7'd0, soundCmdStb}, 8'd0);
		checkByte("soundCmd", soundCmd, 8'd0);
		closeTest("state after reset");
		for (int i = 0; i < numVecs; i++) begin
			runCycle(i);
		end
		$display("Tests %0d, failed %0d, check errors %0d", testsRun, testsFailed, totalErrors);
		if (totalErrors == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

	// Worst case per cycle is maxWaits plus a few edges of setup, hold and release
	initial begin
		#(((numVecs * (maxWaits + 6)) + resetCycles + 2) * periodNs);
		$display("Timeout: the bus cycles did not finish in the expected time");
		$display("Regression failed");
		$finish;
	end

endmodule

`default_nettype wire
